// File: regfile_exec.f
design/rf_pkg.sv
design/exec_pkg.sv
design/clock_gate.sv
design/latch_regfile.sv
design/alu.sv
design/exec_stage.sv
design/regfile_exec_top.sv
sim/tb_clock.sv
sim/regfile_exec_properties.sv
sim/regfile_exec_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f regfile_exec.f --top-module regfile_exec_tb -Mdir obj_dir

out=$(./obj_dir/Vregfile_exec_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'ALL TESTS PASSED'; then
  exit 0
else
  exit 1
fi

// File: sim/regfile_exec_tb.sv
/*
 * Directed tests, one task per behavior, against a register model with x0 at zero.
 * Inputs change on rising edges; outputs are sampled on falling edges.
 */

`default_nettype none

module regfile_exec_tb
  import rf_pkg::*;
  import exec_pkg::*;
();

  logic     clk_int;
  logic     rst_ni;
  logic     test_en_i;
  logic     instr_valid_i;
  alu_op_e  instr_op_i;
  rf_addr_t instr_rd_i;
  rf_addr_t instr_rs1_i;
  rf_addr_t instr_rs2_i;
  imm_t     instr_imm_i;
  logic     result_valid_o;
  rf_addr_t result_rd_o;
  rf_data_t result_o;

  // Architectural register mirror
  rf_data_t model_rf [NUM_WORDS];

  int unsigned checks;
  int unsigned value_errors;
  int unsigned other_errors;

  tb_clock tb_clock_i (
    .clk_o(clk_int)
  );

  regfile_exec_top regfile_exec_top_i (
    .clk_int       (clk_int),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .instr_valid_i (instr_valid_i),
    .instr_op_i    (instr_op_i),
    .instr_rd_i    (instr_rd_i),
    .instr_rs1_i   (instr_rs1_i),
    .instr_rs2_i   (instr_rs2_i),
    .instr_imm_i   (instr_imm_i),
    .result_valid_o(result_valid_o),
    .result_rd_o   (result_rd_o),
    .result_o      (result_o)
  );

  // Two's complement value of the immediate at word width
  function automatic rf_data_t sext_imm(imm_t imm);
    rf_data_t value;
    value = rf_data_t'(imm);
    if (imm[IMM_WIDTH-1]) begin
      value = value - (rf_data_t'(1) << IMM_WIDTH);
    end
    return value;
  endfunction

  // Expected result from the model state before the instruction
  function automatic rf_data_t expected_result(alu_op_e op, rf_addr_t rs1, rf_addr_t rs2,
                                               imm_t imm);
    rf_data_t a;
    rf_data_t b;
    a = model_rf[rs1];
    b = (op == OP_ADDI) ? sext_imm(imm) : model_rf[rs2];
    case (op)
      OP_ADD, OP_ADDI: return a + b;
      OP_SUB: return a - b;
      OP_AND: return a & b;
      OP_OR: return a | b;
      OP_XOR: return a ^ b;
      // Shift by the low 5 bits only
      OP_SLL: return a << b[4:0];
      OP_SRL: return a >> b[4:0];
      default: return a;
    endcase
  endfunction

  // Reads and x0 targets leave the model alone
  function automatic void commit(alu_op_e op, rf_addr_t rd, rf_data_t value);
    if (op != OP_READ && rd != '0) begin
      model_rf[rd] = value;
    end
  endfunction

  task automatic check_data(string name, rf_data_t got, rf_data_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_addr(string name, rf_addr_t got, rf_addr_t exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      value_errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Present one instruction at the current edge
  task automatic drive(alu_op_e op, rf_addr_t rd, rf_addr_t rs1, rf_addr_t rs2, imm_t imm);
    instr_valid_i <= 1'b1;
    instr_op_i    <= op;
    instr_rd_i    <= rd;
    instr_rs1_i   <= rs1;
    instr_rs2_i   <= rs2;
    instr_imm_i   <= imm;
  endtask

  // Poll for the result that must show in the first cycle after the strobe
  task automatic wait_result();
    int unsigned cycles;
    @(negedge clk_int);
    cycles = 1;
    while (result_valid_o !== 1'b1 && cycles < 20) begin
      @(negedge clk_int);
      cycles++;
    end
    if (result_valid_o !== 1'b1) begin
      other_errors++;
      $display("Timed out after %0d cycles waiting for result_valid_o", cycles);
    end else if (cycles != 1) begin
      other_errors++;
      $display("Result arrived %0d cycles after the strobe instead of 1", cycles);
    end
  endtask

  // Single instruction followed by an idle cycle
  task automatic run_instr(alu_op_e op, rf_addr_t rd, rf_addr_t rs1, rf_addr_t rs2, imm_t imm);
    rf_data_t exp;
    @(posedge clk_int);
    drive(op, rd, rs1, rs2, imm);
    exp = expected_result(op, rs1, rs2, imm);
    commit(op, rd, exp);
    @(posedge clk_int);
    instr_valid_i <= 1'b0;
    wait_result();
    check_addr("result_rd_o", result_rd_o, rd);
    check_data("result_o", result_o, exp);
  endtask

  // Result valid stays low without a strobe
  task automatic idle_check(int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk_int);
      check_flag("result_valid_o", result_valid_o, 1'b0);
    end
  endtask

  task automatic write_read_all();
    for (int r = 1; r < NUM_WORDS; r++) begin
      run_instr(OP_ADDI, rf_addr_t'(r), '0, '0, imm_t'($urandom()));
    end
    for (int r = 1; r < NUM_WORDS; r++) begin
      run_instr(OP_READ, rf_addr_t'(r), rf_addr_t'(r), '0, '0);
    end
  endtask

  task automatic alu_op_sweep();
    alu_op_e ops [7];
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL};
    foreach (ops[k]) begin
      run_instr(OP_ADDI, 5'd10, '0, '0, imm_t'($urandom()));
      run_instr(OP_ADDI, 5'd11, '0, '0, imm_t'($urandom()));
      run_instr(ops[k], 5'd12, 5'd10, 5'd11, '0);
    end
  endtask

  task automatic zero_register();
    // Result still shows while the write is dropped
    run_instr(OP_ADDI, '0, '0, '0, imm_t'($urandom()));
    run_instr(OP_ADD, '0, 5'd1, 5'd2, '0);
    run_instr(OP_READ, '0, '0, '0, '0);
    run_instr(OP_READ, 5'd7, '0, '0, '0);
    // OP_READ above left x7 untouched
    run_instr(OP_READ, 5'd7, 5'd7, '0, '0);
    run_instr(OP_ADD, 5'd13, '0, '0, '0);
  endtask

  // Strobes in consecutive cycles that each depend on the previous rd
  task automatic dependent_chain();
    alu_op_e  op;
    rf_addr_t rd;
    rf_addr_t rs;
    rf_addr_t prev_rd;
    rf_data_t exp;
    rf_data_t prev_exp;
    imm_t     imm;
    rd = '0;
    exp = '0;
    for (int i = 0; i <= 6; i++) begin
      @(posedge clk_int);
      if (i < 6) begin
        rd  = rf_addr_t'(20 + i);
        rs  = (i == 0) ? rf_addr_t'(0) : prev_rd;
        imm = imm_t'($urandom());
        op  = (i == 0) ? OP_ADDI : ((i % 2 == 1) ? OP_ADD : OP_SLL);
        drive(op, rd, rs, rs, imm);
        exp = expected_result(op, rs, rs, imm);
        commit(op, rd, exp);
      end else begin
        instr_valid_i <= 1'b0;
      end
      @(negedge clk_int);
      if (i > 0) begin
        check_flag("result_valid_o", result_valid_o, 1'b1);
        check_addr("result_rd_o", result_rd_o, prev_rd);
        check_data("result_o", result_o, prev_exp);
      end
      prev_rd  = rd;
      prev_exp = exp;
    end
    for (int r = 20; r < 26; r++) begin
      run_instr(OP_READ, rf_addr_t'(r), rf_addr_t'(r), '0, '0);
    end
  endtask

  // Scan enable opens every word gate so one write fills them all
  task automatic scan_fill();
    imm_t imm;
    imm = imm_t'($urandom());
    @(posedge clk_int);
    test_en_i <= 1'b1;
    run_instr(OP_ADDI, 5'd1, '0, '0, imm);
    for (int r = 1; r < NUM_WORDS; r++) begin
      model_rf[r] = sext_imm(imm);
    end
    repeat (2) @(posedge clk_int);
    test_en_i <= 1'b0;
    @(posedge clk_int);
    for (int r = 1; r < NUM_WORDS; r++) begin
      run_instr(OP_READ, rf_addr_t'(r), rf_addr_t'(r), '0, '0);
    end
  endtask

  initial begin
    void'($urandom(32'h6cb7));
    checks        = 0;
    value_errors  = 0;
    other_errors  = 0;
    rst_ni        = 1'b0;
    test_en_i     = 1'b0;
    instr_valid_i = 1'b0;
    instr_op_i    = OP_ADD;
    instr_rd_i    = '0;
    instr_rs1_i   = '0;
    instr_rs2_i   = '0;
    instr_imm_i   = '0;
    foreach (model_rf[r]) begin
      model_rf[r] = '0;
    end

    repeat (16) @(posedge clk_int);
    rst_ni <= 1'b1;
    idle_check(3);

    write_read_all();
    alu_op_sweep();
    zero_register();
    dependent_chain();
    scan_fill();
    idle_check(4);

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule : regfile_exec_tb

`default_nettype wire

// File: sim/regfile_exec_properties.sv
/*
 * Protocol and register file checks bound into the top level.
 * Reports only through failing assertions.
 */

`default_nettype none

module regfile_exec_properties import rf_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input logic     instr_valid_i,
  input logic     result_valid_i,
  input rf_addr_t raddr_a_i,
  input rf_addr_t raddr_b_i,
  input rf_data_t rdata_a_i,
  input rf_data_t rdata_b_i
);

  // Strobe gives a result exactly one cycle later
  valid_follows_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_ni) instr_valid_i |=> result_valid_i
  ) else $error("result_valid_o missing one cycle after a strobe");

  // No strobe, no result
  no_valid_without_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !instr_valid_i |=> !result_valid_i
  ) else $error("result_valid_o high without a strobe");

  // Quiet while in reset
  valid_low_in_reset: assert property (
    @(posedge clk_i) !rst_ni |-> !result_valid_i
  ) else $error("result_valid_o high during reset");

  // Word 0 reads zero on both ports
  zero_word_port_a: assert property (
    @(posedge clk_i) (raddr_a_i == '0) |-> (rdata_a_i == '0)
  ) else $error("read port A returned nonzero data for word 0");

  zero_word_port_b: assert property (
    @(posedge clk_i) (raddr_b_i == '0) |-> (rdata_b_i == '0)
  ) else $error("read port B returned nonzero data for word 0");

endmodule : regfile_exec_properties

bind regfile_exec_top regfile_exec_properties regfile_exec_properties_i (
  .clk_i         (clk_int),
  .rst_ni        (rst_ni),
  .instr_valid_i (instr_valid_i),
  .result_valid_i(result_valid_o),
  .raddr_a_i     (raddr_a),
  .raddr_b_i     (raddr_b),
  .rdata_a_i     (rdata_a),
  .rdata_b_i     (rdata_b)
);

`default_nettype wire

// File: sim/tb_clock.sv
/*
 * Free-running testbench clock, period 20 time units.
 * Starts low, so the first rising edge comes at time 10.
 */

`default_nettype none

module tb_clock (
  output logic clk_o
);

  // Start low
  initial begin
    clk_o = 1'b0;
  end

  // Half period of 10
  always begin
    #10 clk_o = ~clk_o;
  end

endmodule : tb_clock

`default_nettype wire

// File: design/regfile_exec_top.sv
/*
 * Exec stage, ALU and latch register file on one clock.
 * Result ports also form the write-back address and data.
 */

`default_nettype none

module regfile_exec_top import rf_pkg::*; import exec_pkg::*; (
  input  logic     clk_int,
  input  logic     rst_ni,
  input  logic     test_en_i,

  // Instruction
  input  logic     instr_valid_i,
  input  alu_op_e  instr_op_i,
  input  rf_addr_t instr_rd_i,
  input  rf_addr_t instr_rs1_i,
  input  rf_addr_t instr_rs2_i,
  input  imm_t     instr_imm_i,

  // Result
  output logic     result_valid_o,
  output rf_addr_t result_rd_o,
  output rf_data_t result_o
);

  // Read ports
  rf_addr_t raddr_a;
  rf_addr_t raddr_b;
  rf_data_t rdata_a;
  rf_data_t rdata_b;

  // ALU hookup
  alu_op_e  alu_op;
  rf_data_t alu_a;
  rf_data_t alu_b;
  rf_data_t alu_result;

  // Write enable from the exec stage
  logic we;

  exec_stage exec_stage_i (
    .clk_i         (clk_int),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .instr_op_i    (instr_op_i),
    .instr_rd_i    (instr_rd_i),
    .instr_rs1_i   (instr_rs1_i),
    .instr_rs2_i   (instr_rs2_i),
    .instr_imm_i   (instr_imm_i),
    .raddr_a_o     (raddr_a),
    .raddr_b_o     (raddr_b),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .alu_op_o      (alu_op),
    .alu_a_o       (alu_a),
    .alu_b_o       (alu_b),
    .alu_result_i  (alu_result),
    .result_valid_o(result_valid_o),
    .result_rd_o   (result_rd_o),
    .result_o      (result_o),
    .we_o          (we)
  );

  alu alu_i (
    .op_i       (alu_op),
    .operand_a_i(alu_a),
    .operand_b_i(alu_b),
    .result_o   (alu_result)
  );

  // Write-back straight from the result register
  latch_regfile latch_regfile_i (
    .clk_i    (clk_int),
    .rst_ni   (rst_ni),
    .test_en_i(test_en_i),
    .raddr_a_i(raddr_a),
    .rdata_a_o(rdata_a),
    .raddr_b_i(raddr_b),
    .rdata_b_o(rdata_b),
    .waddr_i  (result_rd_o),
    .wdata_i  (result_o),
    .we_i     (we)
  );

endmodule : regfile_exec_top

`default_nettype wire

// File: design/exec_stage.sv
/*
 * One instruction per strobe, no back-pressure, result one cycle later.
 * The register file shows a write only one cycle after it is issued,
 * so the pending write-back is forwarded to the next instruction.
 */

`default_nettype none

module exec_stage import rf_pkg::*; import exec_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  // Instruction strobe and fields
  input  logic     instr_valid_i,
  input  alu_op_e  instr_op_i,
  input  rf_addr_t instr_rd_i,
  input  rf_addr_t instr_rs1_i,
  input  rf_addr_t instr_rs2_i,
  input  imm_t     instr_imm_i,

  // Register file reads
  output rf_addr_t raddr_a_o,
  output rf_addr_t raddr_b_o,
  input  rf_data_t rdata_a_i,
  input  rf_data_t rdata_b_i,

  // ALU
  output alu_op_e  alu_op_o,
  output rf_data_t alu_a_o,
  output rf_data_t alu_b_o,
  input  rf_data_t alu_result_i,

  // Result, doubles as register file write port
  output logic     result_valid_o,
  output rf_addr_t result_rd_o,
  output rf_data_t result_o,
  output logic     we_o
);

  // Control state
  logic valid_q;
  logic we_q;

  // Payload
  rf_addr_t rd_q;
  rf_data_t result_q;

  // Forward hits on the pending write
  logic fwd_a;
  logic fwd_b;

  // Immediate widened to a word
  rf_data_t imm_sext;

  // Instruction writes back
  logic writes_rd;

  // Read addresses straight from the fields
  assign raddr_a_o = instr_rs1_i;
  assign raddr_b_o = instr_rs2_i;

  // we_q already excludes rd 0 and OP_READ
  assign fwd_a = we_q && (rd_q == instr_rs1_i);
  assign fwd_b = we_q && (rd_q == instr_rs2_i);

  assign imm_sext = {{(DATA_WIDTH - IMM_WIDTH){instr_imm_i[IMM_WIDTH-1]}}, instr_imm_i};

  // Operand select
  assign alu_op_o = instr_op_i;
  assign alu_a_o  = fwd_a ? result_q : rdata_a_i;

  always_comb begin
    if (instr_op_i == OP_ADDI) begin
      alu_b_o = imm_sext;
    end else if (fwd_b) begin
      alu_b_o = result_q;
    end else begin
      alu_b_o = rdata_b_i;
    end
  end

  // Writes to x0 and reads are not written back
  assign writes_rd = instr_valid_i && (instr_op_i != OP_READ) && (instr_rd_i != '0);

  // Valid and write flag, one cycle pulse per strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      valid_q <= instr_valid_i;
      we_q    <= writes_rd;
    end
  end

  // Result register, loads only on a strobe
  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      rd_q     <= instr_rd_i;
      result_q <= alu_result_i;
    end
  end

  assign result_valid_o = valid_q;
  assign result_rd_o    = rd_q;
  assign result_o       = result_q;
  assign we_o           = we_q;

endmodule : exec_stage

`default_nettype wire

// File: design/alu.sv
/*
 * Purely combinational, zero latency.
 * Shifts are logical and use only the low bits of operand b.
 * OP_READ passes operand a through unchanged.
 */

`default_nettype none

module alu import rf_pkg::*; import exec_pkg::*; (
  input  alu_op_e  op_i,
  input  rf_data_t operand_a_i,
  input  rf_data_t operand_b_i,
  output rf_data_t result_o
);

  // Shift amount, enough bits to cover the word
  logic [$clog2(DATA_WIDTH)-1:0] shamt;

  assign shamt = operand_b_i[$clog2(DATA_WIDTH)-1:0];

  always_comb begin
    unique case (op_i)
      // ADDI gets its immediate already extended into b
      OP_ADD, OP_ADDI: begin
        result_o = operand_a_i + operand_b_i;
      end
      OP_SUB: begin
        result_o = operand_a_i - operand_b_i;
      end
      OP_AND: begin
        result_o = operand_a_i & operand_b_i;
      end
      OP_OR: begin
        result_o = operand_a_i | operand_b_i;
      end
      OP_XOR: begin
        result_o = operand_a_i ^ operand_b_i;
      end
      OP_SLL: begin
        result_o = operand_a_i << shamt;
      end
      OP_SRL: begin
        result_o = operand_a_i >> shamt;
      end
      OP_READ: begin
        result_o = operand_a_i;
      end
      // Unused encodings give zero
      default: begin
        result_o = '0;
      end
    endcase
  end

endmodule : alu

`default_nettype wire

// File: design/latch_regfile.sv
/*
 * Two read ports, one write port, latch storage behind clock gates.
 * Write data is registered, so a write is readable only in the next cycle.
 * Word 0 reads zero; other words hold X until written.
 * With test_en_i high every word 1 to 31 loads the same write data.
 */

`default_nettype none

module latch_regfile import rf_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     test_en_i,

  // Read port A
  input  rf_addr_t raddr_a_i,
  output rf_data_t rdata_a_o,

  // Read port B
  input  rf_addr_t raddr_b_i,
  output rf_data_t rdata_b_o,

  // Write port
  input  rf_addr_t waddr_i,
  input  rf_data_t wdata_i,
  input  logic     we_i
);

  // Storage, word 0 is a constant
  rf_data_t mem [NUM_WORDS];

  // Gated clock, runs only in write cycles
  logic clk_we;

  // Write data register
  rf_data_t wdata_q;

  // Decoded write address, no entry for word 0
  logic [NUM_WORDS-1:1] waddr_onehot;

  // Per-word gated clocks
  logic [NUM_WORDS-1:1] word_clk;

  // Combinational reads
  assign rdata_a_o = mem[raddr_a_i];
  assign rdata_b_o = mem[raddr_b_i];

  // Global gate on the write enable
  clock_gate cg_we_i (
    .clk_i    (clk_i),
    .en_i     (we_i),
    .test_en_i(test_en_i),
    .clk_o    (clk_we)
  );

  // Capture write data at the edge ending the write cycle
  always_ff @(posedge clk_we or negedge rst_ni) begin
    if (!rst_ni) begin
      wdata_q <= '0;
    end else if (we_i) begin
      wdata_q <= wdata_i;
    end
  end

  // One-hot write select
  always_comb begin
    for (int unsigned i = 1; i < NUM_WORDS; i++) begin
      waddr_onehot[i] = we_i && (waddr_i == rf_addr_t'(i));
    end
  end

  // Hardwired zero
  assign mem[0] = '0;

  for (genvar k = 1; k < NUM_WORDS; k++) begin : gen_word
    // Gate fed by clk_we, so its enable is sampled in the write cycle
    clock_gate cg_word_i (
      .clk_i    (clk_we),
      .en_i     (waddr_onehot[k]),
      .test_en_i(test_en_i),
      .clk_o    (word_clk[k])
    );

    // Transparent in the high phase after the write edge
    // follows wdata_q as it settles after that edge
    always_latch begin
      if (word_clk[k]) begin
        mem[k] <= wdata_q;
      end
    end
  end

endmodule : latch_regfile

`default_nettype wire

// File: design/clock_gate.sv
/*
 * Generic latch-based clock gate, standing in for a library ICG cell.
 * Enable must be stable around the rising edge of clk_i.
 * test_en_i forces the gate open for scan.
 */

`default_nettype none

module clock_gate (
  input  logic clk_i,
  input  logic en_i,
  input  logic test_en_i,
  output logic clk_o
);

  // Enable held through the high phase
  logic en_latched;

  // Transparent while the clock is low
  always_latch begin
    if (!clk_i) begin
      en_latched <= en_i | test_en_i;
    end
  end

  // Latched enable cannot change while clk_i is high, so no glitch
  assign clk_o = clk_i & en_latched;

endmodule : clock_gate

`default_nettype wire

// File: design/exec_pkg.sv
/*
 * Opcodes and instruction fields of the exec stage.
 * The immediate is 12 bits and is always sign-extended to the word width.
 */

`default_nettype none

package exec_pkg;

  // Immediate field width
  localparam int unsigned IMM_WIDTH = 12;

  // Raw immediate as carried by the instruction
  typedef logic [IMM_WIDTH-1:0] imm_t;

  // ALU opcodes, 4-bit encoding
  typedef enum logic [3:0] {
    // rd = rs1 + rs2
    OP_ADD  = 4'h0,
    // rd = rs1 - rs2
    OP_SUB  = 4'h1,
    OP_AND  = 4'h2,
    OP_OR   = 4'h3,
    OP_XOR  = 4'h4,
    // Shift amount from the low bits of rs2
    OP_SLL  = 4'h5,
    OP_SRL  = 4'h6,
    // rd = rs1 + sext(imm)
    OP_ADDI = 4'h7,
    // Result shows rs1, no write-back
    OP_READ = 4'h8
  } alu_op_e;

endpackage : exec_pkg

`default_nettype wire

// File: design/rf_pkg.sv
/*
 * Geometry of the latch register file, fixed at 32 words of 32 bits.
 * There is no embedded 16-word variant, so no module takes a size parameter.
 */

`default_nettype none

package rf_pkg;

  // Word width in bits
  localparam int unsigned DATA_WIDTH = 32;

  // Register index width
  localparam int unsigned ADDR_WIDTH = 5;

  // Word 0 is hardwired to zero and has no storage
  localparam int unsigned NUM_WORDS = 2 ** ADDR_WIDTH;

  // Register index
  typedef logic [ADDR_WIDTH-1:0] rf_addr_t;

  // One data word
  typedef logic [DATA_WIDTH-1:0] rf_data_t;

endpackage : rf_pkg

`default_nettype wire
